//--- Makefile
# Verilator build and run for the debug-trace block

VERILATOR ?= verilator
TOP       ?= tb_had_dbg_info
RTL_TOP   ?= had_dbg_info_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
common/had_dbg_pkg.sv
verilog/had_pipe_decode.sv
pipe_fifo/had_pipe_fifo.sv
verilog/had_snapshot.sv
verilog/had_dbg_info_top.sv
test/tb_clk_gen.sv
test/tb_had_dbg_info.sv

//--- common/had_dbg_pkg.sv
// ==========================================================================
// Debug-trace shared definitions
// Entry widths, pipe-select codes and unit debug snapshot layout
// ==========================================================================
package had_dbg_pkg;

  // ========================================================================
  // Trace entry and write lanes
  // ========================================================================
  localparam int DATA_W    = 64;
  localparam int LANES     = 3;

  // Pipe-select register field
  localparam int PIPESEL_W = 2;

  localparam logic [PIPESEL_W-1:0] PIPESEL_OFF = 2'd0;
  localparam logic [PIPESEL_W-1:0] PIPESEL_IDU = 2'd1;
  localparam logic [PIPESEL_W-1:0] PIPESEL_RTU = 2'd2;
  localparam logic [PIPESEL_W-1:0] PIPESEL_LSU = 2'd3;

  // Payloads narrower than one entry, zero-extended on the lanes
  localparam int ID_INFO_W = 40;
  localparam int ST_ADDR_W = 40;

  // ========================================================================
  // Unit debug snapshot
  // ========================================================================
  localparam int IFU_DBG_W = 83;
  localparam int LSU_DBG_W = 184;
  localparam int IDU_DBG_W = 50;
  localparam int IU_DBG_W  = 10;
  localparam int CP0_DBG_W = 4;
  localparam int RTU_DBG_W = 43;
  localparam int MMU_DBG_W = 34;

  localparam int SNAP_W = IFU_DBG_W + LSU_DBG_W + IDU_DBG_W + IU_DBG_W +
                          CP0_DBG_W + RTU_DBG_W + MMU_DBG_W;

  // 408 bits span seven readout words, the last one partly filled
  localparam int SNAP_WORDS = (SNAP_W + DATA_W - 1) / DATA_W;
  localparam int SNAP_PTR_W = 3;

endpackage

//--- pipe_fifo/had_pipe_fifo.sv
// ==========================================================================
// Trace FIFO
// Up to three writes per cycle, oldest entries overwritten when full
// ==========================================================================
`timescale 1ns/1ps

module had_pipe_fifo
  import had_dbg_pkg::*;
#(
  parameter int DEPTH = 16
)
(
  input  logic                         cpuclk,
  input  logic                         cpurst_b,
  input  logic [LANES-1:0]             lane_wen,
  input  logic [LANES-1:0][DATA_W-1:0] lane_data,
  input  logic                         pipefifo_ren,
  output logic [DATA_W-1:0]            pipefifo_data
);

  localparam int ADDR_W = $clog2(DEPTH);
  // Extra wrap bit tells full from empty
  localparam int PTR_W  = ADDR_W + 1;

  logic [DATA_W-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [PTR_W-1:0] occupancy;
  logic [PTR_W-1:0] free_cnt;
  logic [PTR_W-1:0] wr_cnt;
  logic [PTR_W-1:0] drop_cnt;
  logic             empty;
  logic             rd_take;

  // ========================================================================
  // Occupancy and overflow
  // ========================================================================
  assign occupancy = wptr - rptr;
  assign free_cnt  = PTR_W'(DEPTH) - occupancy;
  assign empty     = (occupancy == '0);

  // Lanes are contiguous from lane 0, so the count is also the span
  always_comb
  begin
    wr_cnt = '0;
    for (int i = 0; i < LANES; i++)
      wr_cnt = wr_cnt + PTR_W'(lane_wen[i]);
  end

  // Entries beyond the free space push out the oldest ones
  always_comb
  begin
    if (wr_cnt > free_cnt)
      drop_cnt = wr_cnt - free_cnt;
    else
      drop_cnt = '0;
  end

  // Read of an empty FIFO leaves the pointers alone
  assign rd_take = pipefifo_ren && !empty;

  // ========================================================================
  // Storage
  // ========================================================================
  always_ff @(posedge cpuclk)
  begin
    for (int i = 0; i < LANES; i++)
    begin
      if (lane_wen[i])
        mem[ADDR_W'(wptr + PTR_W'(i))] <= lane_data[i];
    end
  end

  // ========================================================================
  // Pointers
  // ========================================================================
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      wptr <= wptr + wr_cnt;
      rptr <= rptr + drop_cnt + PTR_W'(rd_take);
    end
  end

  // ========================================================================
  // Registered read port
  // ========================================================================
  // Slot content goes out even when empty, holds between reads
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pipefifo_data <= '0;
    else if (pipefifo_ren)
      pipefifo_data <= mem[rptr[ADDR_W-1:0]];
  end

  ap_occupancy_max: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    occupancy <= PTR_W'(DEPTH));

  // Debug controller keeps reads and trace writes in separate cycles
  ap_no_rd_on_wr: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    !(pipefifo_ren && (|lane_wen)));

endmodule

//--- test/tb_clk_gen.sv
// ==========================================================================
// Testbench clock and reset
// Free-running clock, active-low reset held for the first cycles
// ==========================================================================
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 5
)
(
  output logic cpuclk,
  output logic cpurst_b
);

  initial
  begin
    cpuclk = 1'b0;
    forever #(PERIOD_NS / 2) cpuclk = ~cpuclk;
  end

  // Release on a falling edge, away from the sampling edge
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge cpuclk);
    @(negedge cpuclk);
    cpurst_b = 1'b1;
  end

endmodule

//--- test/tb_had_dbg_info.sv
// ==========================================================================
// Debug-trace block testbench
// Pipe-select, trace FIFO and snapshot checks against reference models
// ==========================================================================
`timescale 1ns/1ps

module tb_had_dbg_info
  import had_dbg_pkg::*;
;

  localparam int DEPTH           = 16;
  localparam int CLK_PERIOD_NS   = 20;
  localparam int RESET_CYCLES    = 5;
  localparam int N_ROUNDS        = 6;
  localparam int N_STORES        = DEPTH / 2 + 3;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_ROUNDS * (2 * DEPTH + 4) +
                                   3 * (DEPTH + 8) + 100;

  logic                            cpuclk;
  logic                            cpurst_b;
  logic                            update_dr_en;
  logic                            pipesel_reg_sel;
  logic [DATA_W-1:0]               wdata;
  logic                            pipefifo_wen;
  logic                            pipefifo_ren;
  logic                            dbgfifo_ren;
  logic [LANES-1:0]                id_inst_vld;
  logic [LANES-1:0][ID_INFO_W-1:0] id_inst_info;
  logic [LANES-1:0]                retire_inst_vld;
  logic [LANES-1:0][DATA_W-1:0]    retire_inst_info;
  logic                            st_req;
  logic [DATA_W-1:0]               st_data;
  logic [ST_ADDR_W-1:0]            st_addr;
  logic                            dbg_ack_info;
  logic [IFU_DBG_W-1:0]            ifu_debug_info;
  logic [LSU_DBG_W-1:0]            lsu_debug_info;
  logic [IDU_DBG_W-1:0]            idu_debug_info;
  logic [IU_DBG_W-1:0]             iu_debug_info;
  logic [CP0_DBG_W-1:0]            cp0_debug_info;
  logic [RTU_DBG_W-1:0]            rtu_debug_info;
  logic [MMU_DBG_W-1:0]            mmu_debug_info;
  logic                            id_trace_en;
  logic                            retire_trace_en;
  logic                            st_trace_en;
  logic [31:0]                     pipesel_data;
  logic [DATA_W-1:0]               pipefifo_data;
  logic [DATA_W-1:0]               dbgfifo_data;
  logic                            dbg_ack_pc;

  // Reference models and expected values
  logic [PIPESEL_W-1:0] model_sel;
  logic [DATA_W-1:0]    fifo_model[$];
  logic [DATA_W-1:0]    snap_model [SNAP_WORDS];
  logic [DATA_W-1:0]    pipe_exp;
  logic                 pipe_exp_vld;
  logic [DATA_W-1:0]    dbg_exp;
  logic                 post_reset_chk;
  logic [31:0]          rand_state;
  int                   errors;
  int                   fifo_reads;
  int                   snap_reads;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) clk_gen_i (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b)
  );

  had_dbg_info_top #(
    .DEPTH (DEPTH)
  ) dut_i (
    .cpuclk           (cpuclk),
    .cpurst_b         (cpurst_b),
    .update_dr_en     (update_dr_en),
    .pipesel_reg_sel  (pipesel_reg_sel),
    .wdata            (wdata),
    .pipefifo_wen     (pipefifo_wen),
    .pipefifo_ren     (pipefifo_ren),
    .dbgfifo_ren      (dbgfifo_ren),
    .id_inst_vld      (id_inst_vld),
    .id_inst_info     (id_inst_info),
    .retire_inst_vld  (retire_inst_vld),
    .retire_inst_info (retire_inst_info),
    .st_req           (st_req),
    .st_data          (st_data),
    .st_addr          (st_addr),
    .dbg_ack_info     (dbg_ack_info),
    .ifu_debug_info   (ifu_debug_info),
    .lsu_debug_info   (lsu_debug_info),
    .idu_debug_info   (idu_debug_info),
    .iu_debug_info    (iu_debug_info),
    .cp0_debug_info   (cp0_debug_info),
    .rtu_debug_info   (rtu_debug_info),
    .mmu_debug_info   (mmu_debug_info),
    .id_trace_en      (id_trace_en),
    .retire_trace_en  (retire_trace_en),
    .st_trace_en      (st_trace_en),
    .pipesel_data     (pipesel_data),
    .pipefifo_data    (pipefifo_data),
    .dbgfifo_data     (dbgfifo_data),
    .dbg_ack_pc       (dbg_ack_pc)
  );

  // ========================================================================
  // Random numbers and helpers
  // ========================================================================
  function logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function logic [63:0] rand64();
    return {next_rand(), next_rand()};
  endfunction

  function logic [255:0] rand_wide();
    logic [255:0] v;
    for (int i = 0; i < 8; i++)
      v[i*32 +: 32] = next_rand();
    return v;
  endfunction

  // Enable order is id, retire, store from msb down
  function automatic logic [2:0] expected_trace_en(logic wen, logic [PIPESEL_W-1:0] sel);
    logic [2:0] en;
    en = 3'b000;
    if (wen)
    begin
      case (sel)
        PIPESEL_IDU: en = 3'b100;
        PIPESEL_RTU: en = 3'b010;
        PIPESEL_LSU: en = 3'b001;
        default:     en = 3'b000;
      endcase
    end
    return en;
  endfunction

  task automatic report_mismatch(string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("Summary: %0d FIFO reads checked, %0d snapshot reads checked, %0d errors",
             fifo_reads, snap_reads, errors);
  endtask

  // Pipe select takes effect the cycle after the register write
  always @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      model_sel <= PIPESEL_OFF;
    else if (update_dr_en && pipesel_reg_sel)
      model_sel <= wdata[PIPESEL_W-1:0];
  end

  // ========================================================================
  // Checks
  // ========================================================================
  ap_reset_state: assert property (@(posedge cpuclk) post_reset_chk |->
    (pipefifo_data == '0) && (dbgfifo_data == '0) && !dbg_ack_pc)
    else report_mismatch("data outputs not zero after reset");

  ap_trace_en: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    {id_trace_en, retire_trace_en, st_trace_en} == expected_trace_en(pipefifo_wen, model_sel))
    else report_mismatch("trace enables do not follow pipe select");

  ap_pipesel: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    pipesel_data == {{(32-PIPESEL_W){1'b0}}, model_sel})
    else report_mismatch("pipesel_data differs from written code");

  ap_fifo_read: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    (pipefifo_ren && pipe_exp_vld) |=> (pipefifo_data == $past(pipe_exp)))
    else report_mismatch("trace FIFO read returned wrong entry");

  ap_ack_delay: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    dbg_ack_pc == $past(dbg_ack_info))
    else report_mismatch("dbg_ack_pc is not the acknowledge delayed one cycle");

  ap_snap_read: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    dbgfifo_ren |=> (dbgfifo_data == $past(dbg_exp)))
    else report_mismatch("snapshot read returned wrong word");

  // ========================================================================
  // Stimulus tasks, all driven on the falling edge
  // ========================================================================
  task automatic clear_strobes();
    update_dr_en    = 1'b0;
    pipesel_reg_sel = 1'b0;
    pipefifo_wen    = 1'b0;
    pipefifo_ren    = 1'b0;
    dbgfifo_ren     = 1'b0;
    dbg_ack_info    = 1'b0;
  endtask

  task automatic idle_cycle();
    @(negedge cpuclk);
    clear_strobes();
  endtask

  task automatic write_dr(logic sel, logic [PIPESEL_W-1:0] code);
    @(negedge cpuclk);
    clear_strobes();
    update_dr_en              = 1'b1;
    pipesel_reg_sel           = sel;
    wdata                     = rand64();
    wdata[PIPESEL_W-1:0]      = code;
  endtask

  // Writes n contiguous lanes of the selected stage and updates the model
  task automatic trace_write(int n);
    logic [LANES-1:0] vld;
    logic [31:0]      r32;
    @(negedge cpuclk);
    clear_strobes();
    vld = LANES'((1 << n) - 1);
    r32 = next_rand();
    for (int i = 0; i < LANES; i++)
    begin
      id_inst_info[i]     = ID_INFO_W'(rand64());
      retire_inst_info[i] = rand64();
    end
    st_data         = rand64();
    st_addr         = ST_ADDR_W'(rand64());
    id_inst_vld     = (model_sel == PIPESEL_IDU) ? vld : LANES'(r32);
    retire_inst_vld = (model_sel == PIPESEL_RTU) ? vld : LANES'(r32 >> 4);
    st_req          = (n > 0);
    pipefifo_wen    = 1'b1;
    case (model_sel)
      PIPESEL_IDU:
        for (int i = 0; i < n; i++)
          fifo_model.push_back(DATA_W'(id_inst_info[i]));
      PIPESEL_RTU:
        for (int i = 0; i < n; i++)
          fifo_model.push_back(retire_inst_info[i]);
      PIPESEL_LSU:
      begin
        fifo_model.push_back(st_data);
        fifo_model.push_back(DATA_W'(st_addr));
      end
      default:
        vld = '0;
    endcase
    // Overflow keeps only the newest entries
    while (fifo_model.size() > DEPTH)
      void'(fifo_model.pop_front());
  endtask

  task automatic trace_read();
    @(negedge cpuclk);
    clear_strobes();
    pipefifo_ren = 1'b1;
    pipe_exp_vld = 1'b0;
    if (fifo_model.size() > 0)
    begin
      pipe_exp     = fifo_model.pop_front();
      pipe_exp_vld = 1'b1;
      fifo_reads++;
    end
  endtask

  task automatic drain_fifo();
    logic [31:0] r32;
    while (fifo_model.size() > 0)
    begin
      trace_read();
      r32 = next_rand();
      if (r32[0])
        idle_cycle();
    end
  endtask

  task automatic randomize_units();
    ifu_debug_info = IFU_DBG_W'(rand_wide());
    lsu_debug_info = LSU_DBG_W'(rand_wide());
    idu_debug_info = IDU_DBG_W'(rand_wide());
    iu_debug_info  = IU_DBG_W'(rand_wide());
    cp0_debug_info = CP0_DBG_W'(rand_wide());
    rtu_debug_info = RTU_DBG_W'(rand_wide());
    mmu_debug_info = MMU_DBG_W'(rand_wide());
  endtask

  // Acknowledge, then record the buses of the cycle after it
  task automatic snapshot_ack();
    logic [SNAP_WORDS*DATA_W-1:0] flat;
    @(negedge cpuclk);
    clear_strobes();
    dbg_ack_info = 1'b1;
    randomize_units();
    idle_cycle();
    randomize_units();
    flat = '0;
    flat[SNAP_W-1:0] = {mmu_debug_info, rtu_debug_info, cp0_debug_info, iu_debug_info,
                        idu_debug_info, lsu_debug_info, ifu_debug_info};
    for (int k = 0; k < SNAP_WORDS; k++)
      snap_model[k] = flat[k*DATA_W +: DATA_W];
    idle_cycle();
    randomize_units();
  endtask

  task automatic snapshot_read(int idx);
    @(negedge cpuclk);
    clear_strobes();
    dbgfifo_ren = 1'b1;
    dbg_exp     = snap_model[idx];
    snap_reads++;
  endtask

  // ========================================================================
  // Test sequence
  // ========================================================================
  initial
  begin
    rand_state       = 32'hda4d275f;
    errors           = 0;
    fifo_reads       = 0;
    snap_reads       = 0;
    post_reset_chk   = 1'b0;
    pipe_exp         = '0;
    pipe_exp_vld     = 1'b0;
    dbg_exp          = '0;
    wdata            = '0;
    id_inst_vld      = '0;
    id_inst_info     = '0;
    retire_inst_vld  = '0;
    retire_inst_info = '0;
    st_req           = 1'b0;
    st_data          = '0;
    st_addr          = '0;
    clear_strobes();
    randomize_units();

    wait (cpurst_b === 1'b1);
    @(negedge cpuclk);
    post_reset_chk = 1'b1;
    @(negedge cpuclk);
    post_reset_chk = 1'b0;

    // Register write without the select bit is ignored
    write_dr(1'b0, PIPESEL_LSU);
    write_dr(1'b1, PIPESEL_RTU);
    idle_cycle();

    // Every mode once, OFF writes must not reach the FIFO
    write_dr(1'b1, PIPESEL_OFF);
    trace_write(3);
    trace_write(2);
    write_dr(1'b1, PIPESEL_IDU);
    trace_write(2);
    write_dr(1'b1, PIPESEL_RTU);
    trace_write(3);
    write_dr(1'b1, PIPESEL_LSU);
    trace_write(1);
    write_dr(1'b1, PIPESEL_OFF);
    trace_write(3);
    drain_fifo();

    // Random decode and retire bursts below the FIFO depth
    for (int r = 0; r < N_ROUNDS; r++)
    begin
      write_dr(1'b1, (r % 2 == 0) ? PIPESEL_IDU : PIPESEL_RTU);
      while (fifo_model.size() + LANES <= DEPTH)
        trace_write(1 + int'(next_rand() % 3));
      drain_fifo();
    end

    // Store overflow
    write_dr(1'b1, PIPESEL_LSU);
    for (int i = 0; i < N_STORES; i++)
      trace_write(2);
    drain_fifo();
    write_dr(1'b1, PIPESEL_OFF);

    // Snapshot capture, full readout, wrap back to word 0
    snapshot_ack();
    for (int k = 0; k < SNAP_WORDS; k++)
      snapshot_read(k);
    idle_cycle();
    snapshot_read(0);
    repeat (3) idle_cycle();

    print_summary();
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
    print_summary();
    $display("Verification failed");
    $finish;
  end

endmodule

//--- verilog/had_dbg_info_top.sv
// ==========================================================================
// Debug-trace block top level
// Pipe-select decode, trace FIFO and unit debug snapshot
// ==========================================================================
`timescale 1ns/1ps

module had_dbg_info_top
  import had_dbg_pkg::*;
#(
  parameter int DEPTH = 16
)
(
  input  logic                            cpuclk,
  input  logic                            cpurst_b,
  input  logic                            update_dr_en,
  input  logic                            pipesel_reg_sel,
  input  logic [DATA_W-1:0]               wdata,
  input  logic                            pipefifo_wen,
  input  logic                            pipefifo_ren,
  input  logic                            dbgfifo_ren,
  input  logic [LANES-1:0]                id_inst_vld,
  input  logic [LANES-1:0][ID_INFO_W-1:0] id_inst_info,
  input  logic [LANES-1:0]                retire_inst_vld,
  input  logic [LANES-1:0][DATA_W-1:0]    retire_inst_info,
  input  logic                            st_req,
  input  logic [DATA_W-1:0]               st_data,
  input  logic [ST_ADDR_W-1:0]            st_addr,
  input  logic                            dbg_ack_info,
  input  logic [IFU_DBG_W-1:0]            ifu_debug_info,
  input  logic [LSU_DBG_W-1:0]            lsu_debug_info,
  input  logic [IDU_DBG_W-1:0]            idu_debug_info,
  input  logic [IU_DBG_W-1:0]             iu_debug_info,
  input  logic [CP0_DBG_W-1:0]            cp0_debug_info,
  input  logic [RTU_DBG_W-1:0]            rtu_debug_info,
  input  logic [MMU_DBG_W-1:0]            mmu_debug_info,
  output logic                            id_trace_en,
  output logic                            retire_trace_en,
  output logic                            st_trace_en,
  output logic [31:0]                     pipesel_data,
  output logic [DATA_W-1:0]               pipefifo_data,
  output logic [DATA_W-1:0]               dbgfifo_data,
  output logic                            dbg_ack_pc
);

  // Write lanes from the decoder into the FIFO
  logic [LANES-1:0]             lane_wen;
  logic [LANES-1:0][DATA_W-1:0] lane_data;

  had_pipe_decode decode_i (
    .cpuclk           (cpuclk),
    .cpurst_b         (cpurst_b),
    .update_dr_en     (update_dr_en),
    .pipesel_reg_sel  (pipesel_reg_sel),
    .wdata            (wdata),
    .pipefifo_wen     (pipefifo_wen),
    .id_inst_vld      (id_inst_vld),
    .id_inst_info     (id_inst_info),
    .retire_inst_vld  (retire_inst_vld),
    .retire_inst_info (retire_inst_info),
    .st_req           (st_req),
    .st_data          (st_data),
    .st_addr          (st_addr),
    .pipesel_data     (pipesel_data),
    .id_trace_en      (id_trace_en),
    .retire_trace_en  (retire_trace_en),
    .st_trace_en      (st_trace_en),
    .lane_wen         (lane_wen),
    .lane_data        (lane_data)
  );

  had_pipe_fifo #(
    .DEPTH (DEPTH)
  ) fifo_i (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .lane_wen      (lane_wen),
    .lane_data     (lane_data),
    .pipefifo_ren  (pipefifo_ren),
    .pipefifo_data (pipefifo_data)
  );

  had_snapshot snapshot_i (
    .cpuclk         (cpuclk),
    .cpurst_b       (cpurst_b),
    .dbg_ack_info   (dbg_ack_info),
    .dbgfifo_ren    (dbgfifo_ren),
    .ifu_debug_info (ifu_debug_info),
    .lsu_debug_info (lsu_debug_info),
    .idu_debug_info (idu_debug_info),
    .iu_debug_info  (iu_debug_info),
    .cp0_debug_info (cp0_debug_info),
    .rtu_debug_info (rtu_debug_info),
    .mmu_debug_info (mmu_debug_info),
    .dbg_ack_pc     (dbg_ack_pc),
    .dbgfifo_data   (dbgfifo_data)
  );

endmodule

//--- verilog/had_pipe_decode.sv
// ==========================================================================
// Pipe-select decoder
// Holds the traced-stage select and steers that stage onto the write lanes
// ==========================================================================
`timescale 1ns/1ps

module had_pipe_decode
  import had_dbg_pkg::*;
(
  input  logic                            cpuclk,
  input  logic                            cpurst_b,
  input  logic                            update_dr_en,
  input  logic                            pipesel_reg_sel,
  input  logic [DATA_W-1:0]               wdata,
  input  logic                            pipefifo_wen,
  input  logic [LANES-1:0]                id_inst_vld,
  input  logic [LANES-1:0][ID_INFO_W-1:0] id_inst_info,
  input  logic [LANES-1:0]                retire_inst_vld,
  input  logic [LANES-1:0][DATA_W-1:0]    retire_inst_info,
  input  logic                            st_req,
  input  logic [DATA_W-1:0]               st_data,
  input  logic [ST_ADDR_W-1:0]            st_addr,
  output logic [31:0]                     pipesel_data,
  output logic                            id_trace_en,
  output logic                            retire_trace_en,
  output logic                            st_trace_en,
  output logic [LANES-1:0]                lane_wen,
  output logic [LANES-1:0][DATA_W-1:0]    lane_data
);

  logic [PIPESEL_W-1:0] pipesel;
  logic [LANES-1:0]     stage_vld;

  // Written from the debug register path, effective next cycle
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pipesel <= PIPESEL_OFF;
    else if (update_dr_en && pipesel_reg_sel)
      pipesel <= wdata[PIPESEL_W-1:0];
  end

  assign pipesel_data = {{(32-PIPESEL_W){1'b0}}, pipesel};

  assign id_trace_en     = pipefifo_wen && (pipesel == PIPESEL_IDU);
  assign retire_trace_en = pipefifo_wen && (pipesel == PIPESEL_RTU);
  assign st_trace_en     = pipefifo_wen && (pipesel == PIPESEL_LSU);

  // ========================================================================
  // Lane steering
  // ========================================================================
  always_comb
  begin
    stage_vld = '0;
    lane_data = '0;
    case (pipesel)
      PIPESEL_IDU:
      begin
        stage_vld = id_inst_vld;
        for (int i = 0; i < LANES; i++)
          lane_data[i] = DATA_W'(id_inst_info[i]);
      end
      PIPESEL_RTU:
      begin
        stage_vld = retire_inst_vld;
        lane_data = retire_inst_info;
      end
      PIPESEL_LSU:
      begin
        // One store fills two entries, data first then address
        stage_vld    = {{(LANES-2){1'b0}}, st_req, st_req};
        lane_data[0] = st_data;
        lane_data[1] = DATA_W'(st_addr);
      end
      default:
        stage_vld = '0;
    endcase
  end

  assign lane_wen = stage_vld & {LANES{pipefifo_wen}};

  ap_one_trace_en: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    $onehot0({id_trace_en, retire_trace_en, st_trace_en}));

  // FIFO places lane i at offset i, so holes in the valids would corrupt it
  ap_lane_contig: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    (lane_wen & LANES'(lane_wen + 1'b1)) == '0);

endmodule

//--- verilog/had_snapshot.sv
// ==========================================================================
// Unit debug snapshot
// Captures unit state after a retire acknowledge and reads it out by word
// ==========================================================================
`timescale 1ns/1ps

module had_snapshot
  import had_dbg_pkg::*;
(
  input  logic                 cpuclk,
  input  logic                 cpurst_b,
  input  logic                 dbg_ack_info,
  input  logic                 dbgfifo_ren,
  input  logic [IFU_DBG_W-1:0] ifu_debug_info,
  input  logic [LSU_DBG_W-1:0] lsu_debug_info,
  input  logic [IDU_DBG_W-1:0] idu_debug_info,
  input  logic [IU_DBG_W-1:0]  iu_debug_info,
  input  logic [CP0_DBG_W-1:0] cp0_debug_info,
  input  logic [RTU_DBG_W-1:0] rtu_debug_info,
  input  logic [MMU_DBG_W-1:0] mmu_debug_info,
  output logic                 dbg_ack_pc,
  output logic [DATA_W-1:0]    dbgfifo_data
);

  logic [SNAP_W-1:0]            snap_bus;
  logic [SNAP_W-1:0]            snap_q;
  logic [SNAP_WORDS*DATA_W-1:0] snap_ext;
  logic [SNAP_PTR_W-1:0]        rd_ptr;
  logic                         ptr_done;
  logic [DATA_W-1:0]            rd_word;

  // MMU in the top bits down to IFU in the bottom
  assign snap_bus = {mmu_debug_info, rtu_debug_info, cp0_debug_info, iu_debug_info,
                     idu_debug_info, lsu_debug_info, ifu_debug_info};

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dbg_ack_pc <= 1'b0;
    else
      dbg_ack_pc <= dbg_ack_info;
  end

  // Holds the unit buses from the cycle after the acknowledge
  always_ff @(posedge cpuclk)
  begin
    if (dbg_ack_pc)
      snap_q <= snap_bus;
  end

  // ========================================================================
  // Word readout
  // ========================================================================
  assign snap_ext = {{(SNAP_WORDS*DATA_W-SNAP_W){1'b0}}, snap_q};
  assign ptr_done = (rd_ptr == SNAP_PTR_W'(SNAP_WORDS));

  always_comb
  begin
    if (ptr_done)
      rd_word = '0;
    else
      rd_word = snap_ext[int'(rd_ptr)*DATA_W +: DATA_W];
  end

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rd_ptr       <= '0;
      dbgfifo_data <= '0;
    end
    else if (dbgfifo_ren)
    begin
      rd_ptr       <= rd_ptr + 1'b1;
      dbgfifo_data <= rd_word;
    end
    else if (ptr_done)
      rd_ptr <= '0;
  end

  ap_ptr_range: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    rd_ptr <= SNAP_PTR_W'(SNAP_WORDS));

endmodule
